// ==== bench/csr_tb_ref.svh ====
`ifndef CSR_TB_REF_SVH
`define CSR_TB_REF_SVH

xlen_t model_q [0:4095];  // One word per CSR address

// Bits that a write may change
function automatic xlen_t writable_mask(csr_addr_t addr);
  case (addr)
    CSR_ADDR_MSTATUS: return (xlen_t'(1) << MSTATUS_MIE) | (xlen_t'(1) << MSTATUS_MPIE);
    CSR_ADDR_MIE: begin
      return (xlen_t'(1) << IRQ_BIT_SW) | (xlen_t'(1) << IRQ_BIT_TIMER) |
             (xlen_t'(1) << IRQ_BIT_EXT);
    end
    CSR_ADDR_MTVEC:   return 32'hFFFF_FFFC;  // Mode field fixed at zero
    CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL: return '1;
    default:          return '0;
  endcase
endfunction

function automatic void model_reset();
  foreach (model_q[i]) begin
    model_q[i] = '0;
  end
  model_q[CSR_ADDR_MVENDORID] = CSR_VAL_MVENDORID;
  model_q[CSR_ADDR_MARCHID]   = CSR_VAL_MARCHID;
  model_q[CSR_ADDR_MIMPID]    = CSR_VAL_MIMPID;
  model_q[CSR_ADDR_MHARTID]   = xlen_t'(HART_ID);
  model_q[CSR_ADDR_MISA]      = CSR_VAL_MISA;
  model_q[CSR_ADDR_MTVEC]     = {MTVEC_RST_BASE, 2'b00};
endfunction

// Returns the old value and updates the model
function automatic xlen_t ref_access(csr_op_t op, csr_addr_t addr, xlen_t rs1,
                                     csr_uimm_t uimm);
  xlen_t old_val;
  xlen_t src;
  xlen_t new_val;
  logic  do_wr;
  old_val = model_q[addr];
  src     = (op == CSR_OP_RWI || op == CSR_OP_RSI || op == CSR_OP_RCI) ? {27'd0, uimm} : rs1;
  do_wr   = (op == CSR_OP_RW || op == CSR_OP_RWI) || (src != '0);
  case (op)
    CSR_OP_RW, CSR_OP_RWI: new_val = src;
    CSR_OP_RS, CSR_OP_RSI: new_val = old_val | src;
    CSR_OP_RC, CSR_OP_RCI: new_val = old_val & ~src;
    default:               do_wr = 1'b0;
  endcase
  if (do_wr) begin
    model_q[addr] = (old_val & ~writable_mask(addr)) | (new_val & writable_mask(addr));
  end
  return old_val;
endfunction

function automatic void ref_irq(output logic irq, output xlen_t cause);
  xlen_t act;
  act   = model_q[CSR_ADDR_MIE] & model_q[CSR_ADDR_MIP];
  irq   = model_q[CSR_ADDR_MSTATUS][MSTATUS_MIE] &
          (act[IRQ_BIT_EXT] | act[IRQ_BIT_SW] | act[IRQ_BIT_TIMER]);
  cause = '0;
  if (irq) begin
    cause = act[IRQ_BIT_EXT] ? CAUSE_MEI : (act[IRQ_BIT_SW] ? CAUSE_MSI : CAUSE_MTI);
  end
endfunction

task automatic check_data(string name, xlen_t exp_val, xlen_t act_val);
  n_checks++;
  if (act_val !== exp_val) begin
    n_errors++;
    test_errs++;
    $display("Mismatch %s: rdata expected %h, actual %h", name, exp_val, act_val);
  end
endtask

task automatic check_irq(string name, logic exp_irq, xlen_t exp_cause, logic act_irq,
                         xlen_t act_cause);
  n_checks++;
  if (act_irq !== exp_irq || act_cause !== exp_cause) begin
    n_errors++;
    test_errs++;
    $display("Mismatch %s: irq/cause expected %b/%h, actual %b/%h", name, exp_irq,
             exp_cause, act_irq, act_cause);
  end
endtask

`endif

// ==== bench/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb;
  import csr_pkg::*;

  localparam int HART_ID    = 7;
  localparam int MAX_CYCLES = 2000;
  localparam int N_RAND     = 8;

  logic     clk_i;
  logic     rstn_i;
  csr_req_t req_i;
  logic     sw_irq_i;
  logic     timer_irq_i;
  logic     ext_irq_i;
  xlen_t    rdata_o;
  logic     irq_o;
  xlen_t    irq_cause_o;

  int    n_checks  = 0;
  int    n_errors  = 0;
  int    test_errs = 0;
  int    n_issued  = 0;
  int    n_checked = 0;
  int    cycle_cnt = 0;
  string cur_test  = "reset";
  xlen_t exp_q[$];   // Expected old values in request order
  logic  chk_valid = 1'b0;
  logic  chk_req   = 1'b0;
  xlen_t chk_exp;

  csr_addr_t rw_addrs [4] = '{CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL};
  csr_addr_t all_addrs [17] = '{
    CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID, CSR_ADDR_MIMPID, CSR_ADDR_MHARTID, CSR_ADDR_MSTATUS,
    CSR_ADDR_MISA, CSR_ADDR_MIE, CSR_ADDR_MTVEC, CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC,
    CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL, CSR_ADDR_MIP,
    12'h000, 12'h345, 12'h7C0, 12'hFFF  // Unknown
  };

  `include "csr_tb_ref.svh"

  csr_unit_top #(.HART_ID(HART_ID)) csr_unit_top_inst (
    .clk_i(clk_i), .rstn_i(rstn_i), .req_i(req_i),
    .sw_irq_i(sw_irq_i), .timer_irq_i(timer_irq_i), .ext_irq_i(ext_irq_i),
    .rdata_o(rdata_o), .irq_o(irq_o), .irq_cause_o(irq_cause_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles, test %s did not finish", cycle_cnt, cur_test);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Result checking

  // Request taken at this edge, otherwise rdata_o must hold
  always @(posedge clk_i) begin
    chk_valid = rstn_i;
    chk_req   = 1'b0;
    if (!rstn_i) begin
      chk_exp = '0;  // rdata_o clears in reset
    end else if (req_i.en) begin
      chk_exp = exp_q.pop_front();
      chk_req = 1'b1;
    end
  end

  always @(negedge clk_i) begin
    if (chk_valid) begin
      check_data(cur_test, chk_exp, rdata_o);  // rdata_o settled half a cycle ago
      if (chk_req) begin
        n_checked++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers

  task automatic issue_req(csr_op_t op, csr_addr_t addr, xlen_t rs1, csr_uimm_t uimm);
    @(negedge clk_i);
    req_i = '{en: 1'b1, op: op, addr: addr, rs1: rs1, uimm: uimm};
    exp_q.push_back(ref_access(op, addr, rs1, uimm));
    n_issued++;
  endtask

  task automatic read_csr(csr_addr_t addr);
    issue_req(CSR_OP_RS, addr, '0, '0);  // x0 source, read only
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
    req_i.en = 1'b0;
  endtask

  // Lines change now and are sampled at the next edge
  task automatic drive_lines(logic sw, logic tmr, logic ext);
    sw_irq_i    = sw;
    timer_irq_i = tmr;
    ext_irq_i   = ext;
    model_q[CSR_ADDR_MIP] = (xlen_t'(sw) << IRQ_BIT_SW) | (xlen_t'(tmr) << IRQ_BIT_TIMER) |
                            (xlen_t'(ext) << IRQ_BIT_EXT);
  endtask

  task automatic sample_irq();
    logic  e_irq;
    xlen_t e_cause;
    idle_cycle();
    ref_irq(e_irq, e_cause);
    check_irq(cur_test, e_irq, e_cause, irq_o, irq_cause_o);
  endtask

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    idle_cycle();
    wait (n_checked == n_issued);
    if (test_errs == 0) begin
      $display("%s: passed", cur_test);
    end else begin
      $display("%s: failed with %0d errors", cur_test, test_errs);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    xlen_t mst;
    void'($urandom(32'h420c8f29));
    clk_i  = 1'b0;
    rstn_i = 1'b0;
    req_i  = '0;
    drive_lines(1'b0, 1'b0, 1'b0);
    model_reset();
    repeat (5) @(negedge clk_i);
    rstn_i = 1'b1;

    start_test("reset_values");
    sample_irq();
    foreach (all_addrs[i]) read_csr(all_addrs[i]);
    finish_test();

    start_test("csrrw_data");
    for (int i = 0; i < N_RAND; i++) begin
      foreach (rw_addrs[j]) begin
        issue_req(CSR_OP_RW, rw_addrs[j], $urandom(), '0);
        if ($urandom_range(1) == 1) idle_cycle();  // Mix gaps with back-to-back
        read_csr(rw_addrs[j]);
      end
    end
    finish_test();

    start_test("set_clear");
    for (int i = 0; i < N_RAND; i++) begin
      foreach (rw_addrs[j]) begin
        issue_req(CSR_OP_RS, rw_addrs[j], $urandom(), '0);
        issue_req(CSR_OP_RC, rw_addrs[j], $urandom(), '0);
        issue_req(CSR_OP_RC, rw_addrs[j], '0, '0);  // Zero mask
        read_csr(rw_addrs[j]);
      end
    end
    finish_test();

    start_test("imm_and_fields");
    foreach (rw_addrs[j]) begin
      issue_req(CSR_OP_RWI, rw_addrs[j], '0, $urandom_range(31));
      issue_req(CSR_OP_RSI, rw_addrs[j], '0, $urandom_range(31));
      issue_req(CSR_OP_RCI, rw_addrs[j], '0, $urandom_range(31));
      issue_req(CSR_OP_RCI, rw_addrs[j], '0, '0);
      read_csr(rw_addrs[j]);
    end
    foreach (all_addrs[i]) begin
      issue_req(CSR_OP_RW, all_addrs[i], '1, '0);
      read_csr(all_addrs[i]);
    end
    finish_test();

    start_test("irq_priority");
    for (int i = 0; i < 40; i++) begin
      mst              = $urandom();
      mst[MSTATUS_MIE] = ($urandom_range(3) != 0);  // Mostly enabled
      issue_req(CSR_OP_RW, CSR_ADDR_MSTATUS, mst, '0);
      issue_req(CSR_OP_RW, CSR_ADDR_MIE, $urandom(), '0);
      drive_lines($urandom_range(1), $urandom_range(1), $urandom_range(1));
      sample_irq();
      read_csr(CSR_ADDR_MIP);
    end
    finish_test();

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== common/csr_pkg.sv ====
package csr_pkg;

  //////////////////////////////////////////////////
  // Widths and types

  localparam int unsigned XLEN         = 32;
  localparam int unsigned CSR_ADDR_W   = 12;
  localparam int unsigned CSR_UIMM_W   = 5;
  localparam int unsigned MTVEC_BASE_W = 30;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_UIMM_W-1:0] csr_uimm_t;
  typedef logic [2:0]            csr_op_t;     // Same encoding as funct3

  // Operation codes
  localparam csr_op_t CSR_OP_RW  = 3'd1;
  localparam csr_op_t CSR_OP_RS  = 3'd2;
  localparam csr_op_t CSR_OP_RC  = 3'd3;
  localparam csr_op_t CSR_OP_RWI = 3'd5;
  localparam csr_op_t CSR_OP_RSI = 3'd6;
  localparam csr_op_t CSR_OP_RCI = 3'd7;

  typedef struct packed {
    logic      en;
    csr_op_t   op;
    csr_addr_t addr;
    xlen_t     rs1;
    csr_uimm_t uimm;
  } csr_req_t;

  // Index 0 is software, 1 timer, 2 external
  typedef struct packed {
    logic       glb_en;  // mstatus.MIE
    logic [2:0] en;      // MEIE, MTIE, MSIE
    logic [2:0] pend;    // MEIP, MTIP, MSIP
  } csr_irq_state_t;

  //////////////////////////////////////////////////
  // Machine mode addresses

  localparam csr_addr_t CSR_ADDR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_ADDR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_ADDR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_ADDR_MHARTID   = 12'hF14;
  localparam csr_addr_t CSR_ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_ADDR_MISA      = 12'h301;
  localparam csr_addr_t CSR_ADDR_MIE       = 12'h304;
  localparam csr_addr_t CSR_ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_ADDR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_ADDR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_ADDR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_ADDR_MIP       = 12'h344;

  // Constant ID values
  localparam xlen_t CSR_VAL_MVENDORID = 32'h0000_0000;  // Non-commercial
  localparam xlen_t CSR_VAL_MARCHID   = 32'h0000_0000;
  localparam xlen_t CSR_VAL_MIMPID    = 32'h0000_0001;
  localparam xlen_t CSR_VAL_MISA      = 32'h4000_0100;  // MXL=1, I extension

  localparam logic [MTVEC_BASE_W-1:0] MTVEC_RST_BASE = 30'h0000_0020;  // Byte 0x80

  // Bit positions
  localparam int unsigned MSTATUS_MIE   = 3;
  localparam int unsigned MSTATUS_MPIE  = 7;
  localparam int unsigned IRQ_BIT_SW    = 3;   // mie and mip alike
  localparam int unsigned IRQ_BIT_TIMER = 7;
  localparam int unsigned IRQ_BIT_EXT   = 11;

  // Interrupt causes
  localparam xlen_t CAUSE_MSI = 32'h8000_0003;
  localparam xlen_t CAUSE_MTI = 32'h8000_0007;
  localparam xlen_t CAUSE_MEI = 32'h8000_000B;

endpackage

// ==== csr/csr_op_unit.sv ====
`timescale 1ns/1ps

module csr_op_unit (
  input  csr_pkg::csr_req_t req_i,
  input  csr_pkg::xlen_t    cur_i,    // Current value of the addressed CSR
  output logic              we_o,
  output csr_pkg::xlen_t    wdata_o
);
  import csr_pkg::*;

  xlen_t src;
  logic  src_nz;

  // funct3[2] selects the zero-extended immediate
  assign src    = req_i.op[2] ? xlen_t'(req_i.uimm) : req_i.rs1;
  assign src_nz = |src;

  //////////////////////////////////////////////////
  // Read-modify-write rule

  always_comb begin
    we_o    = 1'b0;
    wdata_o = cur_i;

    if (req_i.en) begin
      case (req_i.op)
        CSR_OP_RW, CSR_OP_RWI: begin
          we_o    = 1'b1;  // Always writes, even with x0
          wdata_o = src;
        end

        CSR_OP_RS, CSR_OP_RSI: begin
          we_o    = src_nz;  // Zero source only reads
          wdata_o = cur_i | src;
        end

        CSR_OP_RC, CSR_OP_RCI: begin
          we_o    = src_nz;
          wdata_o = cur_i & ~src;
        end

        default: begin
          // funct3 0 and 4 are not CSR ops, leave state alone
          we_o    = 1'b0;
          wdata_o = cur_i;
        end
      endcase
    end
  end

endmodule

// ==== csr/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile #(
  parameter int HART_ID = 0
) (
  input  logic                    clk_i,
  input  logic                    rstn_i,

  // Access port
  input  csr_pkg::csr_addr_t      addr_i,
  input  logic                    rd_en_i,
  input  logic                    we_i,
  input  csr_pkg::xlen_t          wdata_i,

  // Interrupt lines
  input  logic                    sw_irq_i,
  input  logic                    timer_irq_i,
  input  logic                    ext_irq_i,

  output csr_pkg::xlen_t          cur_o,
  output csr_pkg::xlen_t          rdata_o,
  output csr_pkg::csr_irq_state_t irq_state_o
);
  import csr_pkg::*;

  // mstatus
  logic mstatus_mie_q;   // Global interrupt enable
  logic mstatus_mpie_q;  // Previous MIE

  logic [MTVEC_BASE_W-1:0] mtvec_base_q;

  // Index 0 sw, 1 timer, 2 ext
  logic [2:0] mie_q;
  logic [2:0] mip_q;

  xlen_t mscratch_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mtval_q;

  // Assembled read layouts
  xlen_t mstatus_val;
  xlen_t mie_val;
  xlen_t mip_val;

  //////////////////////////////////////////////////
  // Read layouts

  always_comb begin
    mstatus_val               = '0;
    mstatus_val[MSTATUS_MIE]  = mstatus_mie_q;
    mstatus_val[MSTATUS_MPIE] = mstatus_mpie_q;

    mie_val                = '0;
    mie_val[IRQ_BIT_SW]    = mie_q[0];
    mie_val[IRQ_BIT_TIMER] = mie_q[1];
    mie_val[IRQ_BIT_EXT]   = mie_q[2];

    mip_val                = '0;
    mip_val[IRQ_BIT_SW]    = mip_q[0];
    mip_val[IRQ_BIT_TIMER] = mip_q[1];
    mip_val[IRQ_BIT_EXT]   = mip_q[2];
  end

  //////////////////////////////////////////////////
  // Read multiplexer

  always_comb begin
    case (addr_i)
      CSR_ADDR_MVENDORID: cur_o = CSR_VAL_MVENDORID;
      CSR_ADDR_MARCHID:   cur_o = CSR_VAL_MARCHID;
      CSR_ADDR_MIMPID:    cur_o = CSR_VAL_MIMPID;
      CSR_ADDR_MHARTID:   cur_o = xlen_t'(HART_ID);
      CSR_ADDR_MISA:      cur_o = CSR_VAL_MISA;
      CSR_ADDR_MSTATUS:   cur_o = mstatus_val;
      CSR_ADDR_MIE:       cur_o = mie_val;
      CSR_ADDR_MIP:       cur_o = mip_val;
      CSR_ADDR_MTVEC:     cur_o = {mtvec_base_q, 2'b00};  // Direct mode only
      CSR_ADDR_MSCRATCH:  cur_o = mscratch_q;
      CSR_ADDR_MEPC:      cur_o = mepc_q;
      CSR_ADDR_MCAUSE:    cur_o = mcause_q;
      CSR_ADDR_MTVAL:     cur_o = mtval_q;
      default:            cur_o = '0;  // Unknown address
    endcase
  end

  // Old value goes out one cycle after the request
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rdata_o <= '0;
    end else if (rd_en_i) begin
      rdata_o <= cur_o;
    end
  end

  //////////////////////////////////////////////////
  // Write port

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mtvec_base_q   <= MTVEC_RST_BASE;
      mie_q          <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
    end else if (we_i) begin
      case (addr_i)
        CSR_ADDR_MSTATUS: begin
          mstatus_mie_q  <= wdata_i[MSTATUS_MIE];
          mstatus_mpie_q <= wdata_i[MSTATUS_MPIE];
        end
        CSR_ADDR_MIE: begin
          mie_q <= {wdata_i[IRQ_BIT_EXT], wdata_i[IRQ_BIT_TIMER], wdata_i[IRQ_BIT_SW]};
        end
        CSR_ADDR_MTVEC:    mtvec_base_q <= wdata_i[XLEN-1:2];  // Mode bits stay zero
        CSR_ADDR_MSCRATCH: mscratch_q   <= wdata_i;
        CSR_ADDR_MEPC:     mepc_q       <= wdata_i;
        CSR_ADDR_MCAUSE:   mcause_q     <= wdata_i;
        CSR_ADDR_MTVAL:    mtval_q      <= wdata_i;
        default: begin
          // ID registers, mip and unknown addresses drop the write
        end
      endcase
    end
  end

  // Pending bits follow the lines with one cycle of delay
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= {ext_irq_i, timer_irq_i, sw_irq_i};
    end
  end

  assign irq_state_o = '{glb_en: mstatus_mie_q, en: mie_q, pend: mip_q};

endmodule

// ==== design/csr_unit_top.sv ====
`timescale 1ns/1ps

module csr_unit_top #(
  parameter int HART_ID = 0
) (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  csr_pkg::csr_req_t req_i,
  input  logic              sw_irq_i,
  input  logic              timer_irq_i,
  input  logic              ext_irq_i,
  output csr_pkg::xlen_t    rdata_o,
  output logic              irq_o,
  output csr_pkg::xlen_t    irq_cause_o
);
  import csr_pkg::*;

  xlen_t          cur;        // Addressed CSR, combinational
  logic           we;
  xlen_t          wdata;
  csr_irq_state_t irq_state;

  //////////////////////////////////////////////////
  // Instruction decode

  csr_op_unit csr_op_unit_inst (
    .req_i   (req_i),
    .cur_i   (cur),
    .we_o    (we),
    .wdata_o (wdata)
  );

  // Register storage
  csr_regfile #(
    .HART_ID (HART_ID)
  ) csr_regfile_inst (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .addr_i      (req_i.addr),
    .rd_en_i     (req_i.en),
    .we_i        (we),
    .wdata_i     (wdata),
    .sw_irq_i    (sw_irq_i),
    .timer_irq_i (timer_irq_i),
    .ext_irq_i   (ext_irq_i),
    .cur_o       (cur),
    .rdata_o     (rdata_o),
    .irq_state_o (irq_state)
  );

  irq_arbiter irq_arbiter_inst (
    .irq_state_i (irq_state),
    .irq_o       (irq_o),
    .irq_cause_o (irq_cause_o)
  );

endmodule

// ==== design/irq_arbiter.sv ====
`timescale 1ns/1ps

module irq_arbiter (
  input  csr_pkg::csr_irq_state_t irq_state_i,
  output logic                    irq_o,
  output csr_pkg::xlen_t          irq_cause_o
);
  import csr_pkg::*;

  logic [2:0] active;  // Enabled and pending
  logic       any_active;

  assign active     = irq_state_i.pend & irq_state_i.en;
  assign any_active = |active;

  // Global enable gates the whole request
  assign irq_o = irq_state_i.glb_en & any_active;

  //////////////////////////////////////////////////
  // Priority select

  // External first, then software, then timer
  always_comb begin
    irq_cause_o = '0;

    if (irq_o) begin
      if (active[2]) begin
        irq_cause_o = CAUSE_MEI;
      end else if (active[0]) begin
        irq_cause_o = CAUSE_MSI;
      end else begin
        irq_cause_o = CAUSE_MTI;  // Only timer is left
      end
    end
  end

endmodule

// ==== verilog.f ====
+incdir+bench
common/csr_pkg.sv
csr/csr_op_unit.sv
csr/csr_regfile.sv
design/irq_arbiter.sv
design/csr_unit_top.sv
bench/csr_tb.sv
